// ==== hdl/regfile_pkg.sv ====
`default_nettype none

package regfile_pkg;

    localparam int NUM_REGS = 8;  // eax..edi.

    typedef logic [2:0]  reg_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [6:0]  tag_t;
    typedef logic [2:0]  sect_mask_t;  // {e, h, l}.

    typedef enum logic [1:0] {
        SZ_8    = 2'd0,
        SZ_16   = 2'd1,
        SZ_32   = 2'd2,
        SZ_NONE = 2'd3
    } size_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } wr_port_t;

    typedef struct packed {
        sect_mask_t  ld;
        sect_mask_t  ren;
        logic [15:0] e_din;
        logic [7:0]  h_din;
        logic [7:0]  l_din;
    } entry_wr_t;

    typedef struct packed {
        word_t      data;
        sect_mask_t pending;
        tag_t       e_tag;
        tag_t       h_tag;
        tag_t       l_tag;
    } rd_result_t;

    typedef struct packed {
        logic [15:0] e;
        logic [7:0]  h;
        logic [7:0]  l;
        tag_t        e_tag;
        tag_t        h_tag;
        tag_t        l_tag;
        sect_mask_t  pending;
    } entry_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // x86 byte aliasing: 8-bit addresses 4..7 are AH, CH, DH, BH.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic reg_addr_t alias_reg(input reg_addr_t addr, input size_t size);
        if (size == SZ_8 && addr[2]) begin
            return {1'b0, addr[1:0]};  // high byte of reg 0..3.
        end
        return addr;
    endfunction

    function automatic sect_mask_t alias_mask(input reg_addr_t addr, input size_t size);
        case (size)
            SZ_8:    return addr[2] ? 3'b010 : 3'b001;
            SZ_16:   return 3'b011;
            SZ_32:   return 3'b111;
            default: return 3'b000;  // no access.
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== hdl/gpr_write_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpr_write_decode
    import regfile_pkg::*;
#(
    parameter int NUM_PORTS = 2
) (
    input  wr_port_t  [NUM_PORTS-1:0] wr,
    input  size_t                     wr_size,
    input  reg_addr_t [NUM_PORTS-1:0] rd_addr,
    input  size_t                     rd_size,
    input  logic      [NUM_PORTS-1:0] rename,
    output entry_wr_t [NUM_REGS-1:0]  entry_wr
);

    reg_addr_t  [NUM_PORTS-1:0] wr_reg;
    sect_mask_t [NUM_PORTS-1:0] wr_msk;
    logic       [NUM_PORTS-1:0][7:0] h_lane;
    reg_addr_t  [NUM_PORTS-1:0] ren_reg;
    sect_mask_t [NUM_PORTS-1:0] ren_msk;
    logic       [NUM_PORTS-1:0] wr_en_vec;
    logic                       any_wr_en;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per-port address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        assign wr_en_vec[p] = wr[p].en;
        assign wr_reg[p]    = alias_reg(wr[p].addr, wr_size);
        assign wr_msk[p]    = wr[p].en ? alias_mask(wr[p].addr, wr_size) : '0;
        // 8-bit writes always source the low byte of the port data.
        assign h_lane[p]    = (wr_size == SZ_8) ? wr[p].data[7:0] : wr[p].data[15:8];

        assign ren_reg[p]   = alias_reg(rd_addr[p], rd_size);
        assign ren_msk[p]   = rename[p] ? alias_mask(rd_addr[p], rd_size) : '0;
    end

    assign any_wr_en = |wr_en_vec;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per-register merge, later ports override earlier ones
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int r = 0; r < NUM_REGS; r++) begin
            entry_wr[r] = '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (wr_reg[p] == reg_addr_t'(r)) begin
                    if (wr_msk[p][2]) begin
                        entry_wr[r].ld[2] = 1'b1;
                        entry_wr[r].e_din = wr[p].data[31:16];
                    end
                    if (wr_msk[p][1]) begin
                        entry_wr[r].ld[1] = 1'b1;
                        entry_wr[r].h_din = h_lane[p];
                    end
                    if (wr_msk[p][0]) begin
                        entry_wr[r].ld[0] = 1'b1;
                        entry_wr[r].l_din = wr[p].data[7:0];
                    end
                end
                if (ren_reg[p] == reg_addr_t'(r)) begin
                    entry_wr[r].ren = entry_wr[r].ren | ren_msk[p];  // shared tag.
                end
            end
        end
    end

    always_comb begin
        if (any_wr_en) begin
            assert (!$isunknown(wr_size))
                else $error("write size is unknown while a write port is enabled");
        end
    end

endmodule

`default_nettype wire

// ==== hdl/gpr_entry.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpr_entry
    import regfile_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  entry_wr_t    entry_wr,
    input  tag_t         wb_tag,
    input  tag_t         new_tag,
    input  logic         flush,
    output entry_state_t state
);

    logic [15:0]     e_q;
    logic [7:0]      h_q;
    logic [7:0]      l_q;
    tag_t [2:0]      tag_q;      // indexed like sect_mask_t.
    sect_mask_t      pending_q;
    sect_mask_t      tag_hit;
    sect_mask_t      pending_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pending bit update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int s = 0; s < 3; s++) begin
            tag_hit[s] = entry_wr.ld[s] && (wb_tag == tag_q[s]);  // producer done.
        end
    end

    // rename beats flush and writeback.
    assign pending_nxt = entry_wr.ren | (pending_q & ~tag_hit & {3{~flush}});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            e_q       <= '0;
            h_q       <= '0;
            l_q       <= '0;
            tag_q     <= '0;
            pending_q <= '0;
        end else begin
            if (entry_wr.ld[2]) begin
                e_q <= entry_wr.e_din;
            end
            if (entry_wr.ld[1]) begin
                h_q <= entry_wr.h_din;
            end
            if (entry_wr.ld[0]) begin
                l_q <= entry_wr.l_din;
            end
            for (int s = 0; s < 3; s++) begin
                if (entry_wr.ren[s]) begin
                    tag_q[s] <= new_tag;
                end
            end
            pending_q <= pending_nxt;
        end
    end

    assign state.e       = e_q;
    assign state.h       = h_q;
    assign state.l       = l_q;
    assign state.e_tag   = tag_q[2];
    assign state.h_tag   = tag_q[1];
    assign state.l_tag   = tag_q[0];
    assign state.pending = pending_q;

    a_flush_clears: assert property (
        @(posedge clk) disable iff (!arst_n)
        (flush && entry_wr.ren == '0) |=> (state.pending == '0)
    ) else $error("pending bits survived a flush");

endmodule

`default_nettype wire

// ==== hdl/gpr_read_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpr_read_select
    import regfile_pkg::*;
#(
    parameter int NUM_PORTS = 2
) (
    input  entry_state_t [NUM_REGS-1:0]  state,
    input  reg_addr_t    [NUM_PORTS-1:0] rd_addr,
    input  size_t                        rd_size,
    output rd_result_t   [NUM_PORTS-1:0] rd_result
);

    reg_addr_t    [NUM_PORTS-1:0] sel_reg;
    sect_mask_t   [NUM_PORTS-1:0] sel_msk;
    entry_state_t [NUM_PORTS-1:0] sel_st;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register pick
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_pick
        assign sel_reg[p] = alias_reg(rd_addr[p], rd_size);
        assign sel_msk[p] = alias_mask(rd_addr[p], rd_size);
        assign sel_st[p]  = state[sel_reg[p]];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result assembly, zero-extended
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            case (rd_size)
                SZ_8: begin
                    // ah..bh come back in the low byte.
                    if (sel_msk[p][1]) begin
                        rd_result[p].data = {24'h0, sel_st[p].h};
                    end else begin
                        rd_result[p].data = {24'h0, sel_st[p].l};
                    end
                end
                SZ_16:   rd_result[p].data = {16'h0, sel_st[p].h, sel_st[p].l};
                SZ_32:   rd_result[p].data = {sel_st[p].e, sel_st[p].h, sel_st[p].l};
                default: rd_result[p].data = '0;
            endcase

            rd_result[p].pending = sel_st[p].pending & sel_msk[p];
            rd_result[p].e_tag   = sel_msk[p][2] ? sel_st[p].e_tag : '0;
            rd_result[p].h_tag   = sel_msk[p][1] ? sel_st[p].h_tag : '0;
            rd_result[p].l_tag   = sel_msk[p][0] ? sel_st[p].l_tag : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/gpr_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpr_regfile
    import regfile_pkg::*;
#(
    parameter int NUM_PORTS = 2
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  wr_port_t     [NUM_PORTS-1:0] wr,
    input  size_t                        wr_size,
    input  tag_t                         wb_tag,
    input  reg_addr_t    [NUM_PORTS-1:0] rd_addr,
    input  size_t                        rd_size,
    input  logic         [NUM_PORTS-1:0] rename,
    input  tag_t                         new_tag,
    input  logic                         flush,
    output rd_result_t   [NUM_PORTS-1:0] rd_result
);

    entry_wr_t    [NUM_REGS-1:0] entry_wr;
    entry_state_t [NUM_REGS-1:0] entry_state;

    gpr_write_decode #(
        .NUM_PORTS (NUM_PORTS)
    ) i_write_decode (
        .wr       (wr),
        .wr_size  (wr_size),
        .rd_addr  (rd_addr),
        .rd_size  (rd_size),
        .rename   (rename),
        .entry_wr (entry_wr)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // architectural registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar r = 0; r < NUM_REGS; r++) begin : g_entry
        gpr_entry i_entry (
            .clk      (clk),
            .arst_n   (arst_n),
            .entry_wr (entry_wr[r]),
            .wb_tag   (wb_tag),
            .new_tag  (new_tag),
            .flush    (flush),
            .state    (entry_state[r])
        );
    end

    gpr_read_select #(
        .NUM_PORTS (NUM_PORTS)
    ) i_read_select (
        .state     (entry_state),
        .rd_addr   (rd_addr),
        .rd_size   (rd_size),
        .rd_result (rd_result)
    );

endmodule

`default_nettype wire

// ==== test/gpr_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpr_checker
    import regfile_pkg::*;
#(
    parameter int NUM_PORTS = 2
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  wr_port_t   [NUM_PORTS-1:0] wr,
    input  size_t                      wr_size,
    input  tag_t                       wb_tag,
    input  reg_addr_t  [NUM_PORTS-1:0] rd_addr,
    input  size_t                      rd_size,
    input  logic       [NUM_PORTS-1:0] rename,
    input  tag_t                       new_tag,
    input  logic                       flush,
    input  rd_result_t [NUM_PORTS-1:0] rd_result,
    input  logic       [159:0]         test_name,
    output int                         errors,
    output int                         checks
);

    logic [15:0] m_e [NUM_REGS];
    logic [7:0]  m_h [NUM_REGS];
    logic [7:0]  m_l [NUM_REGS];
    tag_t        m_tag [NUM_REGS][3];  // [2] is E, [0] is L.
    sect_mask_t  m_pend [NUM_REGS];
    int          err_cnt = 0;
    int          chk_cnt = 0;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic reg_addr_t access_reg(input reg_addr_t addr, input size_t size);
        if (size == SZ_8 && addr >= 3'd4) begin
            return addr - 3'd4;  // ah, ch, dh, bh.
        end
        return addr;
    endfunction

    function automatic sect_mask_t access_mask(input reg_addr_t addr, input size_t size);
        if (size == SZ_32) begin
            return 3'b111;
        end
        if (size == SZ_16) begin
            return 3'b011;
        end
        if (size == SZ_8) begin
            return (addr < 3'd4) ? 3'b001 : 3'b010;
        end
        return 3'b000;
    endfunction

    function automatic rd_result_t expect_read(input reg_addr_t addr, input size_t size);
        rd_result_t res;
        reg_addr_t  r;
        sect_mask_t m;
        r   = access_reg(addr, size);
        m   = access_mask(addr, size);
        res = '0;
        if (m == 3'b010) begin
            res.data = {24'h0, m_h[r]};
        end else if (m == 3'b001) begin
            res.data = {24'h0, m_l[r]};
        end else if (m == 3'b011) begin
            res.data = {16'h0, m_h[r], m_l[r]};
        end else if (m == 3'b111) begin
            res.data = {m_e[r], m_h[r], m_l[r]};
        end
        res.pending = m_pend[r] & m;
        res.e_tag   = m[2] ? m_tag[r][2] : '0;
        res.h_tag   = m[1] ? m_tag[r][1] : '0;
        res.l_tag   = m[0] ? m_tag[r][0] : '0;
        return res;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < NUM_REGS; i++) begin
            m_e[i]    = '0;
            m_h[i]    = '0;
            m_l[i]    = '0;
            m_pend[i] = '0;
            for (int s = 0; s < 3; s++) begin
                m_tag[i][s] = '0;
            end
        end
    endtask

    task automatic apply_cycle();
        sect_mask_t  ld [NUM_REGS];
        sect_mask_t  ren [NUM_REGS];
        logic [15:0] e_in [NUM_REGS];
        logic [7:0]  h_in [NUM_REGS];
        logic [7:0]  l_in [NUM_REGS];
        reg_addr_t   r;
        sect_mask_t  m;
        logic        hit;
        for (int i = 0; i < NUM_REGS; i++) begin
            ld[i]   = '0;
            ren[i]  = '0;
            e_in[i] = '0;
            h_in[i] = '0;
            l_in[i] = '0;
        end
        // later ports overwrite earlier ones.
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (wr[p].en) begin
                r = access_reg(wr[p].addr, wr_size);
                m = access_mask(wr[p].addr, wr_size);
                ld[r] = ld[r] | m;
                if (m[2]) begin
                    e_in[r] = wr[p].data[31:16];
                end
                if (m[1]) begin
                    h_in[r] = (wr_size == SZ_8) ? wr[p].data[7:0] : wr[p].data[15:8];
                end
                if (m[0]) begin
                    l_in[r] = wr[p].data[7:0];
                end
            end
            if (rename[p]) begin
                r = access_reg(rd_addr[p], rd_size);
                ren[r] = ren[r] | access_mask(rd_addr[p], rd_size);
            end
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            for (int s = 0; s < 3; s++) begin
                hit = ld[i][s] && (wb_tag == m_tag[i][s]);  // old tag.
                if (ren[i][s]) begin
                    m_pend[i][s] = 1'b1;
                    m_tag[i][s]  = new_tag;
                end else if (flush || hit) begin
                    m_pend[i][s] = 1'b0;
                end
            end
            if (ld[i][2]) begin
                m_e[i] = e_in[i];
            end
            if (ld[i][1]) begin
                m_h[i] = h_in[i];
            end
            if (ld[i][0]) begin
                m_l[i] = l_in[i];
            end
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clear_model();
        end else begin
            apply_cycle();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare on the falling edge, inputs and reads are settled
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic compare_port(input int p);
        rd_result_t exp;
        exp = expect_read(rd_addr[p], rd_size);
        chk_cnt++;
        if (rd_result[p] !== exp) begin
            err_cnt++;
            $display("FAILED %0s port %0d: expected %h, actual %h",
                     test_name, p, exp, rd_result[p]);
        end
    endtask

    always @(negedge clk) begin
        if (arst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                compare_port(p);
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_gpr_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_gpr_regfile
    import regfile_pkg::*;
();

    localparam int NUM_PORTS   = 2;
    localparam int CLK_PERIOD  = 100;
    localparam int N_RANDOM    = 1500;
    localparam int TEST_CYCLES = N_RANDOM + 100;  // directed part stays under 100.

    logic                       clk;
    logic                       arst_n;
    wr_port_t   [NUM_PORTS-1:0] wr;
    size_t                      wr_size;
    tag_t                       wb_tag;
    reg_addr_t  [NUM_PORTS-1:0] rd_addr;
    size_t                      rd_size;
    logic       [NUM_PORTS-1:0] rename;
    tag_t                       new_tag;
    logic                       flush;
    rd_result_t [NUM_PORTS-1:0] rd_result;
    logic       [159:0]         test_name;
    int                         errors;
    int                         checks;

    gpr_regfile #(
        .NUM_PORTS (NUM_PORTS)
    ) i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (wr),
        .wr_size   (wr_size),
        .wb_tag    (wb_tag),
        .rd_addr   (rd_addr),
        .rd_size   (rd_size),
        .rename    (rename),
        .new_tag   (new_tag),
        .flush     (flush),
        .rd_result (rd_result)
    );

    gpr_checker #(
        .NUM_PORTS (NUM_PORTS)
    ) i_checker (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (wr),
        .wr_size   (wr_size),
        .wb_tag    (wb_tag),
        .rd_addr   (rd_addr),
        .rd_size   (rd_size),
        .rename    (rename),
        .new_tag   (new_tag),
        .flush     (flush),
        .rd_result (rd_result),
        .test_name (test_name),
        .errors    (errors),
        .checks    (checks)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [159:0] pack_name(input string s);
        logic [159:0] v;
        v = '0;
        for (int i = 0; i < s.len(); i++) begin
            v = {v[151:0], s[i]};
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;  // drive point.
    endtask

    task automatic idle_inputs();
        for (int p = 0; p < NUM_PORTS; p++) begin
            wr[p] = '0;
        end
        rename = '0;
        flush  = 1'b0;
    endtask

    task automatic drive_write(input int p, input reg_addr_t addr, input word_t data);
        wr[p].en   = 1'b1;
        wr[p].addr = addr;
        wr[p].data = data;
    endtask

    task automatic set_read(input reg_addr_t a0, input reg_addr_t a1, input size_t size);
        rd_addr[0] = a0;
        rd_addr[1] = a1;
        rd_size    = size;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequences
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic sweep_after_reset();
        test_name = pack_name("reset_sweep");
        for (int s = 0; s < 4; s++) begin
            for (int a = 0; a < 8; a++) begin
                set_read(reg_addr_t'(a), reg_addr_t'(7 - a), size_t'(s));
                next_cycle();
            end
        end
    endtask

    task automatic sized_writes();
        test_name = pack_name("sized_write");
        wr_size   = SZ_32;
        drive_write(0, 3'd0, 32'h1234_5678);
        set_read(3'd0, 3'd4, SZ_32);
        next_cycle();
        idle_inputs();
        wr_size = SZ_8;
        drive_write(0, 3'd4, 32'hffff_ffab);  // ah.
        next_cycle();
        idle_inputs();
        next_cycle();
        set_read(3'd0, 3'd4, SZ_16);
        next_cycle();
        wr_size = SZ_NONE;
        drive_write(0, 3'd0, 32'hdead_beef);
        drive_write(1, 3'd2, 32'hcafe_f00d);
        next_cycle();
        idle_inputs();
        set_read(3'd0, 3'd2, SZ_32);
        wr_size = SZ_32;
        drive_write(0, 3'd3, 32'h1111_1111);
        drive_write(1, 3'd3, 32'h2222_2222);  // port 1 wins.
        next_cycle();
        idle_inputs();
        set_read(3'd3, 3'd7, SZ_32);
        next_cycle();
    endtask

    task automatic rename_sections();
        test_name = pack_name("rename");
        set_read(3'd0, 3'd5, SZ_32);
        rename  = 2'b01;
        new_tag = 7'h15;
        next_cycle();
        idle_inputs();
        set_read(3'd0, 3'd5, SZ_8);
        rename  = 2'b10;  // ch.
        new_tag = 7'h22;
        next_cycle();
        idle_inputs();
        set_read(3'd0, 3'd1, SZ_32);
        next_cycle();
    endtask

    task automatic writeback_clears();
        test_name = pack_name("writeback");
        wr_size   = SZ_8;
        wb_tag    = 7'h15;
        drive_write(0, 3'd0, 32'h0000_0011);  // al only.
        next_cycle();
        idle_inputs();
        wr_size = SZ_16;
        wb_tag  = 7'h00;
        drive_write(1, 3'd1, 32'h0000_7766);
        next_cycle();
        idle_inputs();
        set_read(3'd1, 3'd0, SZ_32);
        next_cycle();
    endtask

    task automatic flush_pending();
        test_name = pack_name("flush");
        flush     = 1'b1;
        next_cycle();
        idle_inputs();
        next_cycle();
        set_read(3'd4, 3'd5, SZ_8);
        next_cycle();
    endtask

    task automatic random_traffic();
        test_name = pack_name("random");
        for (int i = 0; i < N_RANDOM; i++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                wr[p].en   = 1'($urandom_range(1, 0));
                wr[p].addr = reg_addr_t'($urandom_range(7, 0));
                wr[p].data = $urandom();
                rd_addr[p] = reg_addr_t'($urandom_range(7, 0));
                rename[p]  = 1'($urandom_range(1, 0));
            end
            if ($urandom_range(3, 0) == 0) begin
                wr[1].addr = wr[0].addr;  // same-section conflict.
                rd_addr[1] = rd_addr[0];
            end
            wr_size = size_t'($urandom_range(3, 0));
            rd_size = size_t'($urandom_range(3, 0));
            wb_tag  = tag_t'($urandom_range(7, 0));
            new_tag = tag_t'($urandom_range(7, 0));
            flush   = ($urandom_range(31, 0) == 0);
            next_cycle();
        end
    endtask

    initial begin
        void'($urandom(55315));
        arst_n    = 1'b0;
        wr_size   = SZ_NONE;
        wb_tag    = '0;
        new_tag   = '0;
        rd_addr   = '0;
        rd_size   = SZ_32;
        test_name = pack_name("reset");
        idle_inputs();
        repeat (3) @(posedge clk);
        #10;
        arst_n = 1'b1;
        sweep_after_reset();
        sized_writes();
        rename_sections();
        writeback_clears();
        flush_pending();
        random_traffic();
        idle_inputs();
        next_cycle();
        next_cycle();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("timeout: the run went past twice its planned length");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/regfile_pkg.sv
hdl/gpr_write_decode.sv
hdl/gpr_entry.sv
hdl/gpr_read_select.sv
hdl/gpr_regfile.sv
test/gpr_checker.sv
test/tb_gpr_regfile.sv

// ==== Makefile ====
# Verilator build and run for the GPR register file.

TOP := tb_gpr_regfile

.PHONY: all lint clean

# Build, run, and pass only if the pass line shows up in the output.
all:
	verilator --binary --assert --timescale 1ns/1ns \
		-f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -c '^>>> PASS$$' > /dev/null

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns \
		-f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
